/* hdl/fpm_params.svh */
// width, limit and step-count macros for the FPM exponent slice, included by package and RTL
`ifndef FPM_PARAMS_SVH
`define FPM_PARAMS_SVH

// ----------------------------------------------------------
// datapath widths
// ----------------------------------------------------------

// exponent word as seen on W and D
`define FPM_EXP_W 8
// exponent with the two extension bits d[-1], d[-2]
`define FPM_EXT_W 10
// alignment / iteration step counter
`define FPM_FIC_W 6

// shift distance at which the smaller mantissa vanishes
`define FPM_ALIGN_LIMIT 40

// ----------------------------------------------------------
// step counts loaded into fic on f4
// ----------------------------------------------------------
`define FPM_STEPS_MF 39
`define FPM_STEPS_DW 17
`define FPM_STEPS_MW 16
`define FPM_STEPS_DF 40

`endif

/* hdl/fpm_pkg.sv */
// shared vector types of the FPM exponent slice, imported by the RTL and the testbench
`default_nettype none

`include "fpm_params.svh"

package fpm_pkg;

	// exponent word and its ten-bit two's-complement extension
	typedef logic [`FPM_EXP_W-1:0] exp_t;
	typedef logic [`FPM_EXT_W-1:0] exp_ext_t;

	// step counter value
	typedef logic [`FPM_FIC_W-1:0] fic_t;

	// instruction field ir[7:9]
	typedef logic [2:0] op_code_t;

	// one bit per operation, ad at the msb down to df at the lsb
	typedef logic [7:0] op_onehot_t;

	// B bus select, fcb then scc
	typedef logic [1:0] bbus_mode_t;

	// bit positions inside op_onehot_t
	localparam int unsigned OP_MW = 5;
	localparam int unsigned OP_DW = 4;
	localparam int unsigned OP_AF = 3;
	localparam int unsigned OP_SF = 2;
	localparam int unsigned OP_MF = 1;
	localparam int unsigned OP_DF = 0;

endpackage

`default_nettype wire

/* hdl/fpm_exp_if.sv */
// exponent results passed from the exponent path to the alignment control
`timescale 1ns/10ps
`default_nettype none

interface fpm_exp_if;

	import fpm_pkg::*;

	// adder result, its sign and the two-sided range test
	exp_ext_t sum;
	logic     sum_neg;
	logic     ge_limit;

	// extended D register
	exp_ext_t d_ext;

	modport src (output sum, output sum_neg, output ge_limit, output d_ext);

	modport dst (input sum, input sum_neg, input ge_limit, input d_ext);

endinterface

`default_nettype wire

/* hdl/fpm_exp_path.sv */
// exponent datapath with L bus, D and B registers, B bus, adder and limit test, used by fpm_top
`timescale 1ns/10ps
`default_nettype none

`include "fpm_params.svh"

module fpm_exp_path (
	input  wire                     wdtwtg_clk,
	input  wire                     _0_f,
	input  wire fpm_pkg::exp_t      w,
	input  wire                     lkb,
	input  wire                     l_d,
	input  wire                     clr_d,
	input  wire                     f2,
	input  wire                     strob_fp,
	input  wire fpm_pkg::bbus_mode_t bbus_mode,
	input  wire                     pc8,
	fpm_exp_if.src                  exp,
	output fpm_pkg::exp_t           d
);

	import fpm_pkg::*;

	localparam int EXT_BITS = `FPM_EXT_W - `FPM_EXP_W;

	exp_t     b_reg;
	exp_t     bbus;
	exp_ext_t bbus_ext;
	exp_ext_t lbus;

	logic signed [`FPM_EXT_W-1:0] sum_s;

	// ----------------------------------------------------------
	// L bus and D register
	// ----------------------------------------------------------

	// W comes in sign-extended, otherwise the adder feeds back
	assign lbus = lkb ? {{EXT_BITS{w[`FPM_EXP_W-1]}}, w} : exp.sum;

	// clr_d wins over l_d
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			exp.d_ext <= '0;
		end else if (clr_d) begin
			exp.d_ext <= '0;
		end else if (l_d) begin
			exp.d_ext <= lbus;
		end
	end

	assign d = exp.d_ext[`FPM_EXP_W-1:0];

	// ----------------------------------------------------------
	// B register and B bus
	// ----------------------------------------------------------

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			b_reg <= '0;
		end else if (f2 && strob_fp) begin
			b_reg <= exp.d_ext[`FPM_EXP_W-1:0];
		end
	end

	// inverted B with pc8 set gives the difference D - B
	always_comb begin
		case (bbus_mode)
			2'b00:   bbus = ~b_reg;
			2'b01:   bbus = b_reg;
			2'b10:   bbus = '1;
			default: bbus = '0;
		endcase
	end

	assign bbus_ext = {{EXT_BITS{bbus[`FPM_EXP_W-1]}}, bbus};

	// ----------------------------------------------------------
	// exponent adder and range test
	// ----------------------------------------------------------

	// ten-bit sum wrapping modulo 1024
	assign exp.sum = exp.d_ext + bbus_ext + exp_ext_t'(pc8);
	assign exp.sum_neg = exp.sum[`FPM_EXT_W-1];

	assign sum_s = $signed(exp.sum);

	// difference too large in either direction
	assign exp.ge_limit = (sum_s >= `FPM_ALIGN_LIMIT) || (sum_s <= -`FPM_ALIGN_LIMIT);

endmodule

`default_nettype wire

/* hdl/fpm_op_decode.sv */
// floating-point instruction decoder producing one-hot operations and group flags for fpm_top
`timescale 1ns/10ps
`default_nettype none

module fpm_op_decode (
	input  wire fpm_pkg::op_code_t    ir,
	input  wire                       pufa,
	input  wire                       nrf,
	output fpm_pkg::op_onehot_t       ops,
	output logic                      ff,
	output logic                      ss,
	output logic                      puf
);

	import fpm_pkg::*;

	// ----------------------------------------------------------
	// operation decode
	// ----------------------------------------------------------

	// ir = 0 selects ad at the msb, ir = 7 selects df at the lsb
	always_comb begin
		ops = '0;
		if (pufa) begin
			ops[7 - ir] = 1'b1;
		end
	end

	// ----------------------------------------------------------
	// group outputs
	// ----------------------------------------------------------

	// floating point including normalize
	assign ff = nrf | ir[2];

	// fixed point group ad, sd, mw, dw
	assign ss = pufa & ~ir[2];

	// any arithmetic unit instruction
	assign puf = pufa | nrf;

endmodule

`default_nettype wire

/* hdl/fpm_align_ctl.sv */
// alignment flags g, wdt, wt and the fic step counter driven by the f strobes, used by fpm_top
`timescale 1ns/10ps
`default_nettype none

`include "fpm_params.svh"

module fpm_align_ctl (
	input  wire                      wdtwtg_clk,
	input  wire                      _0_f,
	input  wire                      strob_fp,
	input  wire                      strob2_fp,
	input  wire                      f4,
	input  wire                      f5,
	input  wire                      f8,
	input  wire fpm_pkg::op_onehot_t ops,
	fpm_exp_if.dst                   exp,
	output logic                     g,
	output logic                     wdt,
	output logic                     wt,
	output fpm_pkg::fic_t            fic,
	output logic                     fic_done
);

	import fpm_pkg::*;

	logic af_sf;
	logic capture;
	logic step_load;
	logic fic_load;
	logic fic_clr;
	logic count_en;
	fic_t step_cnt;
	fic_t load_val;

	// ----------------------------------------------------------
	// strobe qualification
	// ----------------------------------------------------------

	assign af_sf = ops[OP_AF] | ops[OP_SF];

	// exponent compare result is taken here
	assign capture = f5 & strob_fp & af_sf;

	assign step_load = f4 & strob_fp;
	assign fic_load = capture | step_load;
	assign count_en = f8 & strob_fp;

	// alignment overflow leaves nothing to shift
	assign fic_clr = strob2_fp & f5 & g;

	// ----------------------------------------------------------
	// alignment flags
	// ----------------------------------------------------------

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			g <= 1'b0;
			wdt <= 1'b0;
			wt <= 1'b0;
		end else if (capture) begin
			g <= exp.ge_limit;
			// negative difference means T gets denormalized
			wdt <= exp.sum_neg;
			wt <= exp.ge_limit & ~exp.sum_neg;
		end
	end

	// ----------------------------------------------------------
	// fic step counter
	// ----------------------------------------------------------

	// operations without a step count load zero
	always_comb begin
		step_cnt = '0;
		if (ops[OP_MF]) begin
			step_cnt = fic_t'(`FPM_STEPS_MF);
		end else if (ops[OP_DW]) begin
			step_cnt = fic_t'(`FPM_STEPS_DW);
		end else if (ops[OP_MW]) begin
			step_cnt = fic_t'(`FPM_STEPS_MW);
		end else if (ops[OP_DF]) begin
			step_cnt = fic_t'(`FPM_STEPS_DF);
		end
	end

	// capture and step-count sources merged by OR
	assign load_val = (capture ? exp.sum[`FPM_FIC_W-1:0] : fic_t'(0))
		| (step_load ? step_cnt : fic_t'(0));

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			fic <= '0;
		end else if (fic_clr) begin
			fic <= '0;
		end else if (fic_load) begin
			fic <= load_val;
		end else if (count_en) begin
			// wdt steers the direction and the count wraps modulo 64
			fic <= wdt ? fic + fic_t'(1) : fic - fic_t'(1);
		end
	end

	assign fic_done = (fic == '0);

endmodule

`default_nettype wire

/* hdl/fpm_top.sv */
// top level of the FPM exponent slice, plain pins wired to the three blocks
`timescale 1ns/10ps
`default_nettype none

module fpm_top (
	input  wire                      wdtwtg_clk,
	input  wire                      _0_f,
	input  wire fpm_pkg::exp_t       w,
	input  wire                      lkb,
	input  wire                      l_d,
	input  wire                      clr_d,
	input  wire                      fcb,
	input  wire                      scc,
	input  wire                      pc8,
	input  wire                      strob_fp,
	input  wire                      strob2_fp,
	input  wire                      f2,
	input  wire                      f4,
	input  wire                      f5,
	input  wire                      f8,
	input  wire fpm_pkg::op_code_t   ir,
	input  wire                      pufa,
	input  wire                      nrf,
	output wire fpm_pkg::exp_t       d,
	output wire                      g,
	output wire                      wdt,
	output wire                      wt,
	output wire fpm_pkg::fic_t       fic,
	output wire                      fic_done,
	output wire fpm_pkg::op_onehot_t ops,
	output wire                      ff,
	output wire                      ss,
	output wire                      puf
);

	import fpm_pkg::*;

	wire bbus_mode_t bbus_mode;

	assign bbus_mode = {fcb, scc};

	// exponent results toward the alignment control
	fpm_exp_if exp_bus ();

	fpm_exp_path u_exp_path (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.w          (w),
		.lkb        (lkb),
		.l_d        (l_d),
		.clr_d      (clr_d),
		.f2         (f2),
		.strob_fp   (strob_fp),
		.bbus_mode  (bbus_mode),
		.pc8        (pc8),
		.exp        (exp_bus.src),
		.d          (d)
	);

	fpm_op_decode u_op_decode (
		.ir   (ir),
		.pufa (pufa),
		.nrf  (nrf),
		.ops  (ops),
		.ff   (ff),
		.ss   (ss),
		.puf  (puf)
	);

	fpm_align_ctl u_align_ctl (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.strob_fp   (strob_fp),
		.strob2_fp  (strob2_fp),
		.f4         (f4),
		.f5         (f5),
		.f8         (f8),
		.ops        (ops),
		.exp        (exp_bus.dst),
		.g          (g),
		.wdt        (wdt),
		.wt         (wt),
		.fic        (fic),
		.fic_done   (fic_done)
	);

endmodule

`default_nettype wire

/* dv/fpm_assert.sv */
// concurrent checks on the FPM top level, attached to every fpm_top instance by bind
`timescale 1ns/10ps
`default_nettype none

module fpm_assert (
	input wire                      wdtwtg_clk,
	input wire                      _0_f,
	input wire                      g,
	input wire                      wdt,
	input wire                      wt,
	input wire fpm_pkg::fic_t       fic,
	input wire                      fic_done,
	input wire fpm_pkg::op_onehot_t ops
);

	int fail_cnt = 0;

	// done flag tracks an empty counter
	done_matches_count: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		fic_done == (fic == '0))
	else begin
		fail_cnt++;
		$error("fic_done disagrees with fic = %0d", fic);
	end

	// decoder raises one operation at most
	ops_onehot: assert property (@(posedge wdtwtg_clk) disable iff (_0_f) $onehot0(ops))
	else begin
		fail_cnt++;
		$error("more than one operation decoded, ops = %b", ops);
	end

	flags_low_after_reset: assert property (@(posedge wdtwtg_clk)
		$fell(_0_f) |-> (!g && !wdt && !wt))
	else begin
		fail_cnt++;
		$error("alignment flags not low after reset");
	end

endmodule

bind fpm_top fpm_assert u_assert (.*);

`default_nettype wire

/* dv/fpm_tb.sv */
// directed testbench for the FPM exponent slice, compiled as top module fpm_tb from the file list
`timescale 1ns/10ps
`default_nettype none

`include "fpm_params.svh"

module fpm_tb;

	import fpm_pkg::*;

	// strobe bits from strob_fp down to f8
	localparam logic [5:0] ST_FP = 6'b100000;
	localparam logic [5:0] ST_FP2 = 6'b010000;
	localparam logic [5:0] ST_F2 = 6'b001000;
	localparam logic [5:0] ST_F4 = 6'b000100;
	localparam logic [5:0] ST_F5 = 6'b000010;
	localparam logic [5:0] ST_F8 = 6'b000001;

	localparam op_code_t IR_AD = 3'd0;
	localparam op_code_t IR_MW = 3'd2;
	localparam op_code_t IR_DW = 3'd3;
	localparam op_code_t IR_AF = 3'd4;
	localparam op_code_t IR_SF = 3'd5;
	localparam op_code_t IR_MF = 3'd6;
	localparam op_code_t IR_DF = 3'd7;

	localparam int STEP_TIMEOUT = 80;

	logic       wdtwtg_clk;
	logic       _0_f;
	exp_t       w;
	logic       lkb;
	logic       l_d;
	logic       clr_d;
	logic       fcb;
	logic       scc;
	logic       pc8;
	logic [5:0] strobes;
	op_code_t   ir;
	logic       pufa;
	logic       nrf;
	exp_t       d;
	logic       g;
	logic       wdt;
	logic       wt;
	fic_t       fic;
	logic       fic_done;
	op_onehot_t ops;
	logic       ff;
	logic       ss;
	logic       puf;

	int          checks;
	int          errors;
	logic [31:0] rng;

	fpm_top UUT (
		.strob_fp  (strobes[5]),
		.strob2_fp (strobes[4]),
		.f2        (strobes[3]),
		.f4        (strobes[2]),
		.f5        (strobes[1]),
		.f8        (strobes[0]),
		.*
	);

	initial begin
		wdtwtg_clk = 1'b0;
		forever #50 wdtwtg_clk = ~wdtwtg_clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_exp(output exp_t v);
		rng = xorshift(rng);
		v = rng[7:0];
	endtask

	// ----------------------------------------------------------
	// checking
	// ----------------------------------------------------------

	task automatic record_check(input logic ok, input string what, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (!ok) begin
			errors++;
			$display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
		end
	endtask

	task automatic compare_exp(input exp_t got, input exp_t want, input string what);
		record_check(got === want, what, 32'(got), 32'(want));
	endtask

	task automatic compare_fic(input fic_t got, input fic_t want, input string what);
		record_check(got === want, what, 32'(got), 32'(want));
	endtask

	task automatic compare_ops(input op_onehot_t got, input op_onehot_t want, input string what);
		record_check(got === want, what, 32'(got), 32'(want));
	endtask

	task automatic compare_bit(input logic got, input logic want, input string what);
		record_check(got === want, what, 32'(got), 32'(want));
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err0);
	endtask

	// ----------------------------------------------------------
	// stimulus tasks that end at a falling edge
	// ----------------------------------------------------------

	task automatic strobe_cycle(input logic [5:0] sel);
		@(posedge wdtwtg_clk);
		strobes <= sel;
		@(posedge wdtwtg_clk);
		strobes <= '0;
		@(negedge wdtwtg_clk);
	endtask

	// from_w picks W over the adder on the L bus
	task automatic load_d(input logic from_w, input exp_t v);
		@(posedge wdtwtg_clk);
		lkb <= from_w;
		w <= v;
		l_d <= 1'b1;
		@(posedge wdtwtg_clk);
		l_d <= 1'b0;
		@(negedge wdtwtg_clk);
	endtask

	task automatic select_op(input op_code_t code);
		@(posedge wdtwtg_clk);
		ir <= code;
		pufa <= 1'b1;
		nrf <= 1'b0;
		@(negedge wdtwtg_clk);
	endtask

	task automatic set_bbus(input bbus_mode_t mode, input logic carry);
		@(posedge wdtwtg_clk);
		fcb <= mode[1];
		scc <= mode[0];
		pc8 <= carry;
		@(negedge wdtwtg_clk);
	endtask

	task automatic count_to_done(output int n);
		n = 0;
		while (!fic_done && n < STEP_TIMEOUT) begin
			strobe_cycle(ST_FP | ST_F8);
			n++;
		end
		if (!fic_done) begin
			errors++;
			$display("timeout: fic_done still low after %0d count cycles", n);
		end
	endtask

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------

	task automatic decode_all_opcodes();
		int         err0;
		op_onehot_t want;
		err0 = errors;
		for (int i = 0; i < 32; i++) begin
			@(posedge wdtwtg_clk);
			ir <= op_code_t'(i);
			pufa <= i[3];
			nrf <= i[4];
			@(negedge wdtwtg_clk);
			want = i[3] ? op_onehot_t'(8'h80 >> i[2:0]) : '0;
			compare_ops(ops, want, "ops");
			compare_bit(ff, i[4] | i[2], "ff");
			compare_bit(ss, i[3] & ~i[2], "ss");
			compare_bit(puf, i[3] | i[4], "puf");
		end
		report_test("decoder", err0);
	endtask

	task automatic load_and_clear_d();
		int   err0;
		exp_t v;
		err0 = errors;
		repeat (4) begin
			next_exp(v);
			load_d(1'b1, v);
			compare_exp(d, v, "d after W load");
		end
		// clr_d wins over a concurrent l_d
		@(posedge wdtwtg_clk);
		clr_d <= 1'b1;
		l_d <= 1'b1;
		@(posedge wdtwtg_clk);
		clr_d <= 1'b0;
		l_d <= 1'b0;
		@(negedge wdtwtg_clk);
		compare_exp(d, '0, "d after clr_d");
		report_test("d load", err0);
	endtask

	task automatic exponent_adder_modes();
		int   err0;
		exp_t a;
		exp_t c;
		exp_t want;
		err0 = errors;
		next_exp(a);
		next_exp(c);
		load_d(1'b1, a);
		strobe_cycle(ST_FP | ST_F2);
		for (int m = 0; m < 4; m++) begin
			load_d(1'b1, c);
			set_bbus(bbus_mode_t'(m), 1'b1);
			load_d(1'b0, c);
			case (m)
				0: want = c - a;
				1: want = c + a + 8'd1;
				2: want = c;
				default: want = c + 8'd1;
			endcase
			compare_exp(d, want, "d from adder");
		end
		report_test("exponent difference", err0);
	endtask

	task automatic alignment_capture();
		int   err0;
		int   diff;
		logic ge;
		exp_t a;
		exp_t c;
		err0 = errors;
		set_bbus(2'b00, 1'b1);
		for (int k = 0; k < 20; k++) begin
			next_exp(a);
			next_exp(c);
			select_op(k[0] ? IR_SF : IR_AF);
			load_d(1'b1, a);
			strobe_cycle(ST_FP | ST_F2);
			load_d(1'b1, c);
			strobe_cycle(ST_FP | ST_F5);
			// signed exponents give the difference c - a
			diff = int'($signed(c)) - int'($signed(a));
			ge = (diff >= `FPM_ALIGN_LIMIT) || (diff <= -`FPM_ALIGN_LIMIT);
			compare_bit(g, ge, "g");
			compare_bit(wdt, diff < 0, "wdt");
			compare_bit(wt, ge && diff >= 0, "wt");
			compare_fic(fic, fic_t'(diff), "fic after capture");
			if (ge) begin
				strobe_cycle(ST_FP2 | ST_F5);
				compare_fic(fic, '0, "fic after overflow clear");
			end
		end
		report_test("alignment", err0);
	endtask

	task automatic step_count_loads();
		int       err0;
		op_code_t codes [5];
		fic_t     wants [5];
		err0 = errors;
		codes = '{IR_MF, IR_DW, IR_MW, IR_DF, IR_AD};
		wants = '{fic_t'(`FPM_STEPS_MF), fic_t'(`FPM_STEPS_DW), fic_t'(`FPM_STEPS_MW),
			fic_t'(`FPM_STEPS_DF), fic_t'(0)};
		for (int k = 0; k < 5; k++) begin
			select_op(codes[k]);
			strobe_cycle(ST_FP | ST_F4);
			compare_fic(fic, wants[k], "fic step count");
		end
		report_test("step counts", err0);
	endtask

	task automatic fic_up_down_count();
		int err0;
		int n;
		err0 = errors;
		// B bus at zero makes the sum equal to D
		set_bbus(2'b11, 1'b0);
		select_op(IR_AF);
		load_d(1'b1, 8'd5);
		strobe_cycle(ST_FP | ST_F5);
		compare_bit(wdt, 1'b0, "wdt before down count");
		select_op(IR_MW);
		strobe_cycle(ST_FP | ST_F4);
		count_to_done(n);
		compare_fic(fic_t'(n), fic_t'(`FPM_STEPS_MW), "down count steps");
		// -3 gives wdt set and fic at 61
		select_op(IR_AF);
		load_d(1'b1, 8'hfd);
		strobe_cycle(ST_FP | ST_F5);
		compare_bit(wdt, 1'b1, "wdt before up count");
		compare_fic(fic, 6'd61, "fic loaded from -3");
		count_to_done(n);
		compare_fic(fic_t'(n), 6'd3, "up count steps to wrap");
		report_test("counting", err0);
	endtask

	initial begin
		_0_f = 1'b1;
		w = '0;
		lkb = 1'b0;
		l_d = 1'b0;
		clr_d = 1'b0;
		fcb = 1'b0;
		scc = 1'b0;
		pc8 = 1'b0;
		strobes = '0;
		ir = '0;
		pufa = 1'b0;
		nrf = 1'b0;
		checks = 0;
		errors = 0;
		rng = 32'h4a1b;
		repeat (8) @(posedge wdtwtg_clk);
		_0_f <= 1'b0;
		@(negedge wdtwtg_clk);
		compare_bit(g | wdt | wt, 1'b0, "flags after reset");
		compare_bit(fic_done, 1'b1, "fic_done after reset");
		report_test("reset", 0);
		decode_all_opcodes();
		load_and_clear_d();
		exponent_adder_modes();
		alignment_capture();
		step_count_loads();
		fic_up_down_count();
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			UUT.u_assert.fail_cnt);
		if (errors == 0 && UUT.u_assert.fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/fpm_pkg.sv
hdl/fpm_exp_if.sv
hdl/fpm_exp_path.sv
hdl/fpm_op_decode.sv
hdl/fpm_align_ctl.sv
hdl/fpm_top.sv
dv/fpm_assert.sv
dv/fpm_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the FPM slice testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module fpm_tb \
	--Mdir obj_dir -o fpm_sim

out=$(./obj_dir/fpm_sim +verilator+error+limit+100 || true)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
	exit 0
fi
exit 1
